/* autocorrPipe.f */
hw/autocorrPkg.sv
hw/sampleStore.sv
hw/lagLane.sv
hw/lagNormalizer.sv
hw/autocorrBusSlave.sv
hw/autocorrPipe.sv
testbench/autocorrPipeTb.sv

/* hw/autocorrBusSlave.sv */
module autocorrBusSlave
	import autocorrPkg::*;
(
	input logic clk,
	input logic rst,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [7:0] adr,
	input logic [31:0] datWr,
	output logic [31:0] datRd,
	output logic ack,
	output logic sampleWe,
	output logic [5:0] sampleIdx,
	output sample_t sampleData,
	input sample_t sampleRdData,
	output logic start,
	input logic runDone,
	input logic [4:0] normShift,
	output logic [3:0] resultIdx,
	input acc_t resultData
);

	logic request;
	logic busy;
	logic [7:0] sampleOff;
	logic [7:0] resultOff;
	logic sampleHit;
	logic resultHit;
	busWord_u wrWord;
	busWord_u rdWord;
	statusWord_t status;

	// One request per ack, the master drops stb on ack
	assign request = cyc && stb && !ack;
	assign wrWord = datWr;

	////////////////////////////////////////
	// Address decode
	////////////////////////////////////////
	assign sampleOff = adr - ADDR_SAMPLE_BASE;
	assign resultOff = adr - ADDR_RESULT_BASE;
	assign sampleHit = sampleOff < 8'(NUM_SAMPLES);
	assign resultHit = resultOff < 8'(NUM_LAGS);
	assign sampleIdx = sampleOff[5:0];
	assign resultIdx = resultOff[3:0];

	assign sampleWe = request && we && sampleHit && !busy;
	assign sampleData = wrWord.sampleView.sample;
	assign start = request && we && adr == ADDR_CTRL && wrWord.ctrlView.start && !busy;

	always_comb
	begin
		status = '0;
		status.busy = busy;
		status.done = runDone;
		status.normShift = normShift;
	end

	// Read mux, unmapped addresses give zero
	always_comb
	begin
		rdWord = '0;
		if (sampleHit)
			rdWord.sampleView.sample = sampleRdData;
		else if (adr == ADDR_STATUS)
			rdWord = status;
		else if (resultHit)
			rdWord = resultData;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ack <= 1'b0;
			busy <= 1'b0;
		end
		else
		begin
			ack <= request;
			if (start)
				busy <= 1'b1;
			else if (runDone)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (request)
			datRd <= rdWord;
	end

	assert property (@(posedge clk) disable iff (rst) ack |=> !ack);

endmodule

/* hw/autocorrPipe.sv */
module autocorrPipe
	import autocorrPkg::*;
#(
	parameter int numSamples = NUM_SAMPLES
)
(
	input logic clk,
	input logic rst,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [7:0] adr,
	input logic [31:0] datWr,
	output logic [31:0] datRd,
	output logic ack
);

	logic sampleWe;
	logic [5:0] sampleIdx;
	sample_t sampleData;
	sample_t sampleRdData;
	logic start;
	logic runDone;
	logic [4:0] normShift;
	logic [3:0] resultIdx;
	acc_t resultData;

	sampleRead_t lane0Req;
	sampleRead_t lane0Rsp;
	sampleRead_t lane1Req;
	sampleRead_t lane1Rsp;
	lagResult_t lane0Result;
	lagResult_t lane1Result;
	logic lane0Done;
	logic lane1Done;

	////////////////////////////////////////
	// Bus side
	////////////////////////////////////////
	autocorrBusSlave i_busSlave (
		.clk(clk),
		.rst(rst),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datWr(datWr),
		.datRd(datRd),
		.ack(ack),
		.sampleWe(sampleWe),
		.sampleIdx(sampleIdx),
		.sampleData(sampleData),
		.sampleRdData(sampleRdData),
		.start(start),
		.runDone(runDone),
		.normShift(normShift),
		.resultIdx(resultIdx),
		.resultData(resultData)
	);

	sampleStore #(.numSamples(numSamples)) i_sampleStore (
		.clk(clk),
		.we(sampleWe),
		.wrIdx(sampleIdx),
		.wrData(sampleData),
		.busIdx(sampleIdx),
		.busData(sampleRdData),
		.lane0Req(lane0Req),
		.lane0Rsp(lane0Rsp),
		.lane1Req(lane1Req),
		.lane1Rsp(lane1Rsp)
	);

	////////////////////////////////////////
	// Even and odd lag lanes
	////////////////////////////////////////
	lagLane #(.numSamples(numSamples), .firstLag(0), .lagStep(2)) i_lagLane0 (
		.clk(clk),
		.rst(rst),
		.start(start),
		.rdIdx(lane0Req),
		.rdSamples(lane0Rsp),
		.result(lane0Result),
		.laneDone(lane0Done)
	);

	lagLane #(.numSamples(numSamples), .firstLag(1), .lagStep(2)) i_lagLane1 (
		.clk(clk),
		.rst(rst),
		.start(start),
		.rdIdx(lane1Req),
		.rdSamples(lane1Rsp),
		.result(lane1Result),
		.laneDone(lane1Done)
	);

	lagNormalizer i_normalizer (
		.clk(clk),
		.rst(rst),
		.start(start),
		.lane0(lane0Result),
		.lane1(lane1Result),
		.lane0Done(lane0Done),
		.lane1Done(lane1Done),
		.runDone(runDone),
		.normShift(normShift),
		.resultIdx(resultIdx),
		.resultData(resultData)
	);

endmodule

/* hw/autocorrPkg.sv */
package autocorrPkg;

	////////////////////////////////////////
	// Frame and lag sizes
	////////////////////////////////////////
	localparam int NUM_SAMPLES = 64;
	localparam int NUM_LAGS = 11;

	typedef logic signed [15:0] sample_t;
	typedef logic signed [31:0] acc_t;

	// Word address map
	localparam logic [7:0] ADDR_SAMPLE_BASE = 8'h00;
	localparam logic [7:0] ADDR_CTRL = 8'h40;
	localparam logic [7:0] ADDR_STATUS = 8'h41;
	localparam logic [7:0] ADDR_RESULT_BASE = 8'h50;

	////////////////////////////////////////
	// Bus word views
	////////////////////////////////////////
	typedef struct packed {
		logic [15:0] reserved;
		sample_t sample;
	} sampleView_t;

	typedef struct packed {
		logic [30:0] reserved;
		logic start;
	} ctrlView_t;

	typedef union packed {
		sampleView_t sampleView;
		ctrlView_t ctrlView;
	} busWord_u;

	// One lane lookup, indices from the lane and samples from the store
	typedef struct packed {
		logic [5:0] leadIdx;
		logic [5:0] lagIdx;
		sample_t leadSample;
		sample_t lagSample;
	} sampleRead_t;

	typedef struct packed {
		logic valid;
		logic [3:0] lag;
		acc_t sum;
	} lagResult_t;

	typedef struct packed {
		logic busy;
		logic done;
		logic [4:0] normShift;
		logic [24:0] pad;
	} statusWord_t;

endpackage

/* hw/lagLane.sv */
module lagLane
	import autocorrPkg::*;
#(
	parameter int numSamples = NUM_SAMPLES,
	parameter int firstLag = 0,
	parameter int lagStep = 2
)
(
	input logic clk,
	input logic rst,
	input logic start,
	output sampleRead_t rdIdx,
	input sampleRead_t rdSamples,
	output lagResult_t result,
	output logic laneDone
);

	// Highest lag of this lane's parity
	localparam int lastLag = firstLag + ((NUM_LAGS - 1 - firstLag) / lagStep) * lagStep;

	logic macActive;
	logic emitActive;
	logic [3:0] lag;
	logic [5:0] n;
	acc_t acc;

	// acc + 2*a*b, saturated to 32 bits
	function automatic acc_t macSat(acc_t sum, sample_t a, sample_t b);
		acc_t prod;
		logic signed [33:0] wide;
		prod = a * b;
		wide = $signed({{2{sum[31]}}, sum}) + $signed({prod[31], prod, 1'b0});
		if (wide[33:31] == 3'b000 || wide[33:31] == 3'b111)
			return wide[31:0];
		else if (wide[33])
			return 32'sh8000_0000;
		else
			return 32'sh7FFF_FFFF;
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			macActive <= 1'b0;
			emitActive <= 1'b0;
			laneDone <= 1'b0;
			lag <= 4'(firstLag);
			n <= 6'(firstLag);
		end
		else if (start)
		begin
			macActive <= 1'b1;
			emitActive <= 1'b0;
			laneDone <= 1'b0;
			lag <= 4'(firstLag);
			n <= 6'(firstLag);
			acc <= '0;
		end
		else if (macActive)
		begin
			acc <= macSat(acc, rdSamples.leadSample, rdSamples.lagSample);
			if (n == 6'(numSamples - 1))
			begin
				macActive <= 1'b0;
				emitActive <= 1'b1;
			end
			else
			begin
				n <= n + 6'd1;
			end
		end
		else if (emitActive)
		begin
			emitActive <= 1'b0;
			if (lag == 4'(lastLag))
			begin
				laneDone <= 1'b1;
			end
			else
			begin
				// Next lag starts at n = k
				macActive <= 1'b1;
				lag <= lag + 4'(lagStep);
				n <= 6'(lag) + 6'(lagStep);
				acc <= '0;
			end
		end
	end

	always_comb
	begin
		rdIdx = '0;
		rdIdx.leadIdx = n;
		rdIdx.lagIdx = n - 6'(lag);
	end

	always_comb
	begin
		result.valid = emitActive;
		result.lag = lag;
		result.sum = acc;
	end

	assert property (@(posedge clk) disable iff (rst) n <= 6'(numSamples - 1));
	// No result once the lane has finished its last lag
	assert property (@(posedge clk) disable iff (rst) result.valid |-> !laneDone);

endmodule

/* hw/lagNormalizer.sv */
module lagNormalizer
	import autocorrPkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input lagResult_t lane0,
	input lagResult_t lane1,
	input logic lane0Done,
	input logic lane1Done,
	output logic runDone,
	output logic [4:0] normShift,
	input logic [3:0] resultIdx,
	output acc_t resultData
);

	acc_t lagMem [NUM_LAGS];
	logic armed;
	logic storePhase;
	logic [3:0] storeIdx;

	// Left shifts until bit 30 differs from bit 31
	function automatic logic [4:0] normCount(acc_t x);
		logic [4:0] count;
		logic found;
		count = '0;
		found = 1'b0;
		for (int i = 30; i >= 0; i--)
		begin
			if (!found && x[i] != x[31])
			begin
				count = 5'(30 - i);
				found = 1'b1;
			end
		end
		if (!found && x != '0)
			count = 5'd31;
		return count;
	endfunction

	function automatic acc_t shlSat(acc_t x, logic [4:0] sh);
		logic signed [63:0] wide;
		wide = $signed({{32{x[31]}}, x}) <<< sh;
		if (wide[63:31] == '0 || wide[63:31] == '1)
			return wide[31:0];
		else if (wide[63])
			return 32'sh8000_0000;
		else
			return 32'sh7FFF_FFFF;
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			armed <= 1'b0;
			storePhase <= 1'b0;
			storeIdx <= '0;
			runDone <= 1'b0;
			normShift <= '0;
			for (int i = 0; i < NUM_LAGS; i++)
				lagMem[i] <= '0;
		end
		else if (start)
		begin
			armed <= 1'b1;
			storePhase <= 1'b0;
			runDone <= 1'b0;
		end
		else
		begin
			// Raw sums by lag number
			if (lane0.valid)
				lagMem[lane0.lag] <= lane0.sum;
			if (lane1.valid)
				lagMem[lane1.lag] <= lane1.sum;

			if (armed && lane0Done && lane1Done)
			begin
				// Shift count in the first cycle with both lanes done
				armed <= 1'b0;
				normShift <= normCount(lagMem[0]);
				storePhase <= 1'b1;
				storeIdx <= '0;
			end
			else if (storePhase)
			begin
				lagMem[storeIdx] <= shlSat(lagMem[storeIdx], normShift);
				if (storeIdx == 4'(NUM_LAGS - 1))
				begin
					storePhase <= 1'b0;
					runDone <= 1'b1;
				end
				else
				begin
					storeIdx <= storeIdx + 4'd1;
				end
			end
		end
	end

	assign resultData = (resultIdx < 4'(NUM_LAGS)) ? lagMem[resultIdx] : '0;

	// Even and odd lanes must never collide on one lag
	assert property (@(posedge clk) disable iff (rst)
		(lane0.valid && lane1.valid) |-> (lane0.lag != lane1.lag));

endmodule

/* hw/sampleStore.sv */
module sampleStore
	import autocorrPkg::*;
#(
	parameter int numSamples = NUM_SAMPLES
)
(
	input logic clk,
	input logic we,
	input logic [5:0] wrIdx,
	input sample_t wrData,
	input logic [5:0] busIdx,
	output sample_t busData,
	input sampleRead_t lane0Req,
	output sampleRead_t lane0Rsp,
	input sampleRead_t lane1Req,
	output sampleRead_t lane1Rsp
);

	sample_t mem [numSamples];

	// Fill both samples of one lookup
	function automatic sampleRead_t lookup(sampleRead_t req);
		sampleRead_t rsp;
		rsp = req;
		rsp.leadSample = mem[req.leadIdx];
		rsp.lagSample = mem[req.lagIdx];
		return rsp;
	endfunction

	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[wrIdx] <= wrData;
		end
	end

	// Bus readback and lane lookups are all combinational
	assign busData = mem[busIdx];
	assign lane0Rsp = lookup(lane0Req);
	assign lane1Rsp = lookup(lane1Req);

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module autocorrPipeTb -f autocorrPipe.f \
	-o autocorrPipeSim && ./obj_dir/autocorrPipeSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* testbench/autocorrPipeTb.sv */
module autocorrPipeTb
	import autocorrPkg::*;
();

	localparam int numSamples = 64;
	// Six runs of compute plus bus traffic, five times over
	localparam int numRuns = 6;
	localparam int runCycles = 400;
	localparam int busCycles = 250;
	localparam int maxCycles = 5 * numRuns * (runCycles + busCycles) + 500;
	localparam longint accMax = 64'sd2147483647;
	localparam longint accMin = -64'sd2147483648;

	logic clk;
	logic rst;
	logic cyc;
	logic stb;
	logic we;
	logic [7:0] adr;
	logic [31:0] datWr;
	logic [31:0] datRd;
	logic ack;

	int cycleCount = 0;
	logic [31:0] rngState;
	sample_t frame [numSamples];
	acc_t expLags [NUM_LAGS];
	logic [4:0] expShift;

	autocorrPipe #(.numSamples(numSamples)) i_autocorrPipe (
		.clk(clk),
		.rst(rst),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datWr(datWr),
		.datRd(datRd),
		.ack(ack)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= maxCycles)
		begin
			$display("The run timed out after %0d cycles", maxCycles);
			$display("Test failures found");
			$fatal(1, "Simulation stopped on timeout");
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////
	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("[ERROR] %s: expected 0x%08h, actual 0x%08h", testName, expected, actual);
			$display("Test failures found");
			$fatal(1, "Stopped at first error");
		end
	endtask

	task automatic checkTrue(input string testName, input logic cond, input string what);
		assert (cond)
		else
		begin
			$display("[ERROR] %s: %s", testName, what);
			$display("Test failures found");
			$fatal(1, "Stopped at first error");
		end
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////
	function automatic acc_t clampTo32(longint v);
		if (v > accMax)
			return 32'sh7FFF_FFFF;
		else if (v < accMin)
			return 32'sh8000_0000;
		else
			return v[31:0];
	endfunction

	// One codec MAC step, twice the product added with saturation
	function automatic acc_t macStep(acc_t acc, sample_t a, sample_t b);
		return clampTo32(longint'(acc) + 64'sd2 * longint'(a) * longint'(b));
	endfunction

	function automatic logic [4:0] normShiftOf(acc_t x);
		logic [31:0] v;
		int s;
		v = x;
		s = 0;
		if (x == 0)
			return 5'd0;
		while (s < 31 && v[31] == v[30])
		begin
			v = v << 1;
			s++;
		end
		return 5'(s);
	endfunction

	function automatic acc_t shiftSat(acc_t x, logic [4:0] s);
		return clampTo32(longint'(x) <<< s);
	endfunction

	// Raw sums of the current frame, then the shift and normalized lags
	function automatic void computeModel();
		acc_t raw [NUM_LAGS];
		acc_t acc;
		for (int k = 0; k < NUM_LAGS; k++)
		begin
			acc = '0;
			for (int n = k; n < numSamples; n++)
				acc = macStep(acc, frame[n], frame[n - k]);
			raw[k] = acc;
		end
		expShift = normShiftOf(raw[0]);
		for (int k = 0; k < NUM_LAGS; k++)
			expLags[k] = shiftSat(raw[k], expShift);
	endfunction

	// Longest lane plus the normalizer, in cycles from start to done
	function automatic int runLatency();
		int laneCycles [2];
		for (int lane = 0; lane < 2; lane++)
		begin
			laneCycles[lane] = 0;
			for (int k = lane; k < NUM_LAGS; k += 2)
				laneCycles[lane] += numSamples - k + 1;
		end
		return ((laneCycles[0] > laneCycles[1]) ? laneCycles[0] : laneCycles[1]) + 12;
	endfunction

	function automatic logic [31:0] xorshift32(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic fillRandom(input int shiftDown);
		for (int i = 0; i < numSamples; i++)
		begin
			rngState = xorshift32(rngState);
			frame[i] = $signed(rngState[15:0]) >>> shiftDown;
		end
	endtask

	////////////////////////////////////////
	// Wishbone master
	////////////////////////////////////////
	task automatic wbWrite(input logic [7:0] a, input logic [31:0] d);
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		adr = a;
		datWr = d;
		@(negedge clk);
		while (!ack)
			@(negedge clk);
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic wbRead(input logic [7:0] a, output logic [31:0] d);
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b0;
		adr = a;
		@(negedge clk);
		while (!ack)
			@(negedge clk);
		d = datRd;
		cyc = 1'b0;
		stb = 1'b0;
	endtask

	task automatic loadFrame();
		for (int i = 0; i < numSamples; i++)
			wbWrite(ADDR_SAMPLE_BASE + 8'(i), {16'h0000, frame[i]});
	endtask

	// Poll status until the done bit shows
	task automatic waitDone(output statusWord_t status);
		logic [31:0] word;
		status = '0;
		while (!status.done)
		begin
			wbRead(ADDR_STATUS, word);
			status = word;
		end
	endtask

	task automatic runAndWait(output statusWord_t status);
		wbWrite(ADDR_CTRL, 32'h1);
		waitDone(status);
	endtask

	task automatic compareResults(input string testName, input statusWord_t status);
		logic [31:0] word;
		checkValue(testName, 32'(expShift), 32'(status.normShift));
		for (int k = 0; k < NUM_LAGS; k++)
		begin
			wbRead(ADDR_RESULT_BASE + 8'(k), word);
			checkValue(testName, expLags[k], word);
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////
	task automatic testReadback();
		logic [31:0] word;
		statusWord_t status;
		wbRead(ADDR_STATUS, word);
		status = word;
		checkValue("testReadback", 32'(0), 32'(status.busy));
		checkValue("testReadback", 32'(0), 32'(status.done));
		// Results clear after reset, unmapped reads give zero
		wbRead(ADDR_RESULT_BASE, word);
		checkValue("testReadback", 32'(0), word);
		wbRead(8'h60, word);
		checkValue("testReadback", 32'(0), word);
		fillRandom(0);
		loadFrame();
		for (int i = 0; i < numSamples; i++)
		begin
			wbRead(ADDR_SAMPLE_BASE + 8'(i), word);
			checkValue("testReadback", {16'h0000, frame[i]}, word);
		end
	endtask

	task automatic testRandomFrame();
		statusWord_t status;
		fillRandom(4);
		computeModel();
		loadFrame();
		runAndWait(status);
		compareResults("testRandomFrame", status);
	endtask

	task automatic testSaturation();
		logic [31:0] word;
		statusWord_t status;
		for (int i = 0; i < numSamples; i++)
			frame[i] = 16'sh7FFF;
		computeModel();
		loadFrame();
		runAndWait(status);
		checkValue("testSaturation", 32'(0), 32'(status.normShift));
		wbRead(ADDR_RESULT_BASE, word);
		checkValue("testSaturation", 32'h7FFF_FFFF, word);
		compareResults("testSaturation", status);
	endtask

	task automatic testZeroFrame();
		logic [31:0] word;
		statusWord_t status;
		for (int i = 0; i < numSamples; i++)
			frame[i] = '0;
		loadFrame();
		runAndWait(status);
		checkValue("testZeroFrame", 32'(0), 32'(status.normShift));
		for (int k = 0; k < NUM_LAGS; k++)
		begin
			wbRead(ADDR_RESULT_BASE + 8'(k), word);
			checkValue("testZeroFrame", 32'(0), word);
		end
	endtask

	task automatic testSmallFrame();
		statusWord_t status;
		fillRandom(9);
		computeModel();
		loadFrame();
		runAndWait(status);
		checkTrue("testSmallFrame", status.normShift != 5'd0,
			"normShift stayed zero for a small-amplitude frame");
		compareResults("testSmallFrame", status);
	endtask

	task automatic testBusyIgnore();
		logic [31:0] word;
		statusWord_t status;
		int startCycle;
		fillRandom(2);
		computeModel();
		loadFrame();
		wbWrite(ADDR_CTRL, 32'h1);
		startCycle = cycleCount;
		wbRead(ADDR_STATUS, word);
		status = word;
		checkValue("testBusyIgnore", 32'(1), 32'(status.busy));
		// Overwrite attempts and a second start mid-run
		for (int i = 0; i < 8; i++)
			wbWrite(ADDR_SAMPLE_BASE + 8'(i), {16'h0000, ~frame[i]});
		wbWrite(ADDR_CTRL, 32'h1);
		waitDone(status);
		// A restarted run ends far past one run, polling adds only a few cycles
		checkTrue("testBusyIgnore", cycleCount - startCycle <= runLatency() + 8,
			"done came too late because the second start restarted the run");
		compareResults("testBusyIgnore", status);
		for (int i = 0; i < 8; i++)
		begin
			wbRead(ADDR_SAMPLE_BASE + 8'(i), word);
			checkValue("testBusyIgnore", {16'h0000, frame[i]}, word);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datWr = '0;
		rngState = 32'd29645;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		testReadback();
		testRandomFrame();
		testSaturation();
		testZeroFrame();
		testSmallFrame();
		testBusyIgnore();

		$display("All tests passed!");
		$finish;
	end

endmodule
